//--- Makefile
SIM = obj_dir/Vpad_bridge_tb

.PHONY: all run clean

all: run

$(SIM): build.f $(wildcard hw/*.sv verif/*.sv include/*.svh)
	verilator --binary --assert --timescale 1ns/1ps --top-module pad_bridge_tb -f build.f

run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx 'Test OK'

clean:
	rm -rf obj_dir

//--- build.f
+incdir+include
hw/pad_pkg.sv
hw/pad_scanner.sv
hw/phase_assembler.sv
hw/serial_reader.sv
hw/pad_bridge_top.sv
verif/pad_bridge_assert.sv
verif/pad_bridge_tb.sv

//--- hw/pad_bridge_top.sv
`timescale 1ns/1ps
`include "pad_consts.svh"

module pad_bridge_top
(
  input  logic                                 I_clock,
  input  logic                                 I_reset,
  input  pad_pkg::pad_lines_t [`PAD_COUNT-1:0] pad_lines,
  output logic                                 select,
  input  logic [`PAD_COUNT-1:0]                load,
  input  logic [`PAD_COUNT-1:0]                rden,
  output logic [`PAD_COUNT-1:0]                data
);

  import pad_pkg::*;

  // scanner to assembler
  pad_lines_t [`PAD_COUNT-1:0]   phase_sample;
  logic                          phase_high;
  logic                          phase_strobe;

  // assembler to reader, held as levels between commits
  button_byte_t [`PAD_COUNT-1:0] committed;

  pad_scanner u_scanner
  (
    .I_clock      (I_clock),
    .I_reset      (I_reset),
    .pad_lines    (pad_lines),
    .select       (select),
    .phase_sample (phase_sample),
    .phase_high   (phase_high),
    .phase_strobe (phase_strobe)
  );

  phase_assembler u_assembler
  (
    .I_clock      (I_clock),
    .I_reset      (I_reset),
    .phase_sample (phase_sample),
    .phase_high   (phase_high),
    .phase_strobe (phase_strobe),
    .committed    (committed)
  );

  // one shift latch per host port
  serial_reader u_reader
  (
    .I_clock   (I_clock),
    .I_reset   (I_reset),
    .committed (committed),
    .load      (load),
    .rden      (rden),
    .data      (data)
  );

endmodule

//--- hw/pad_pkg.sv
`include "pad_consts.svh"

package pad_pkg;

  // the six raw lines of one pad as seen in one select phase, active low
  typedef logic [5:0] pad_lines_t;

  // one committed button byte, active low
  typedef logic [`PAD_BYTE_BITS-1:0] button_byte_t;

  // pad line positions
  // lines 4 and 5 carry different buttons depending on the select level
  localparam int LINE_UP    = 0;
  localparam int LINE_DOWN  = 1;
  localparam int LINE_LEFT  = 2;
  localparam int LINE_RIGHT = 3;
  localparam int LINE_BA    = 4;
  localparam int LINE_CS    = 5;

  // bit positions inside the button byte, the host sees bit 0 first
  localparam int BIT_B     = 0;
  localparam int BIT_A     = 1;
  localparam int BIT_C     = 2;
  localparam int BIT_START = 3;
  localparam int BIT_UP    = 4;
  localparam int BIT_DOWN  = 5;
  localparam int BIT_LEFT  = 6;
  localparam int BIT_RIGHT = 7;

  // no button pressed
  localparam button_byte_t BYTE_IDLE = '1;

endpackage

//--- hw/pad_scanner.sv
`timescale 1ns/1ps
`include "pad_consts.svh"

module pad_scanner
(
  input  logic                                 I_clock,
  input  logic                                 I_reset,
  input  pad_pkg::pad_lines_t [`PAD_COUNT-1:0] pad_lines,
  output logic                                 select,
  output pad_pkg::pad_lines_t [`PAD_COUNT-1:0] phase_sample,
  output logic                                 phase_high,
  output logic                                 phase_strobe
);

  logic [`PAD_DIV_BITS-1:0] divider;
  logic                     phase_end;

  // select follows the top bit of the free-running divider
  assign select = divider[`PAD_DIV_BITS-1];

  // the low bits are all ones in the last cycle of a select phase
  // by then the pad has had a whole phase to settle on the new level
  assign phase_end = &divider[`PAD_DIV_BITS-2:0];

  always_ff @(posedge I_clock)
  begin
    if (I_reset)
    begin
      divider <= '0;
    end
    else
    begin
      divider <= divider + {{(`PAD_DIV_BITS-1){1'b0}}, 1'b1};
    end
  end

  // the strobe comes one cycle after phase_end, together with the sample
  always_ff @(posedge I_clock)
  begin
    if (I_reset)
    begin
      phase_strobe <= 1'b0;
      phase_high   <= 1'b0;
    end
    else
    begin
      phase_strobe <= phase_end;
      if (phase_end)
      begin
        // tag the sample with the phase it was taken in
        phase_high <= select;
      end
    end
  end

  // both pads are sampled on the same edge
  always_ff @(posedge I_clock)
  begin
    for (int p = 0; p < `PAD_COUNT; p++)
    begin
      if (phase_end)
      begin
        phase_sample[p] <= pad_lines[p];
      end
    end
  end

endmodule

//--- hw/phase_assembler.sv
`timescale 1ns/1ps
`include "pad_consts.svh"

module phase_assembler
(
  input  logic                                   I_clock,
  input  logic                                   I_reset,
  input  pad_pkg::pad_lines_t [`PAD_COUNT-1:0]   phase_sample,
  input  logic                                   phase_high,
  input  logic                                   phase_strobe,
  output pad_pkg::button_byte_t [`PAD_COUNT-1:0] committed
);

  import pad_pkg::*;

  logic                          low_strobe;
  logic                          high_strobe;
  logic [`PAD_COUNT-1:0]         low_a;
  logic [`PAD_COUNT-1:0]         low_start;
  button_byte_t [`PAD_COUNT-1:0] next_byte;

  assign low_strobe  = phase_strobe & ~phase_high;
  assign high_strobe = phase_strobe & phase_high;

  // A and Start are only visible while select is low
  // the low phase comes first in every period so these are fresh at the high strobe
  always_ff @(posedge I_clock)
  begin
    for (int p = 0; p < `PAD_COUNT; p++)
    begin
      if (low_strobe)
      begin
        low_a[p]     <= phase_sample[p][LINE_BA];
        low_start[p] <= phase_sample[p][LINE_CS];
      end
    end
  end

  // byte assembly from the high-phase sample plus the stored low-phase bits
  always_comb
  begin
    for (int p = 0; p < `PAD_COUNT; p++)
    begin
      next_byte[p][BIT_UP]    = phase_sample[p][LINE_UP];
      next_byte[p][BIT_DOWN]  = phase_sample[p][LINE_DOWN];
      next_byte[p][BIT_LEFT]  = phase_sample[p][LINE_LEFT];
      next_byte[p][BIT_RIGHT] = phase_sample[p][LINE_RIGHT];
      next_byte[p][BIT_B]     = phase_sample[p][LINE_BA];
      next_byte[p][BIT_C]     = phase_sample[p][LINE_CS];
      next_byte[p][BIT_A]     = low_a[p];
      next_byte[p][BIT_START] = low_start[p];
    end
  end

  // one commit per select period, the reader picks it up on its next load
  always_ff @(posedge I_clock)
  begin
    for (int p = 0; p < `PAD_COUNT; p++)
    begin
      if (I_reset)
      begin
        committed[p] <= BYTE_IDLE;
      end
      else if (high_strobe)
      begin
        committed[p] <= next_byte[p];
      end
    end
  end

endmodule

//--- hw/serial_reader.sv
`timescale 1ns/1ps
`include "pad_consts.svh"

module serial_reader
(
  input  logic                                   I_clock,
  input  logic                                   I_reset,
  input  pad_pkg::button_byte_t [`PAD_COUNT-1:0] committed,
  input  logic [`PAD_COUNT-1:0]                  load,
  input  logic [`PAD_COUNT-1:0]                  rden,
  output logic [`PAD_COUNT-1:0]                  data
);

  import pad_pkg::*;

  logic [`PAD_COUNT-1:0]         rden_q;
  logic [`PAD_COUNT-1:0]         rden_fall;
  button_byte_t [`PAD_COUNT-1:0] shift_latch;

  // the host clocks the next bit on the falling edge of its read strobe
  assign rden_fall = rden_q & ~rden;

  always_comb
  begin
    for (int p = 0; p < `PAD_COUNT; p++)
    begin
      data[p] = shift_latch[p][0];
    end
  end

  always_ff @(posedge I_clock)
  begin
    if (I_reset)
    begin
      rden_q <= '0;
    end
    else
    begin
      rden_q <= rden;
    end
  end

  // load is a level, the latch keeps tracking committed while it is held
  // Load has priority over a shift in the same cycle.
  always_ff @(posedge I_clock)
  begin
    for (int p = 0; p < `PAD_COUNT; p++)
    begin
      if (I_reset)
      begin
        shift_latch[p] <= BYTE_IDLE;
      end
      else if (load[p])
      begin
        shift_latch[p] <= committed[p];
      end
      else if (rden_fall[p])
      begin
        // zeros come in from the top once the byte is used up
        shift_latch[p] <= {1'b0, shift_latch[p][`PAD_BYTE_BITS-1:1]};
      end
    end
  end

endmodule

//--- include/pad_consts.svh
`ifndef PAD_CONSTS_SVH
`define PAD_CONSTS_SVH

// the top bit of the select divider drives the select line
// select toggles every 32 cycles and a full period is 64 cycles
`define PAD_DIV_BITS 6

// number of pad ports on the bridge
`define PAD_COUNT 2

// width of the button byte that is shifted out to the host
`define PAD_BYTE_BITS 8

`endif

//--- verif/pad_bridge_assert.sv
`timescale 1ns/1ps
`include "pad_consts.svh"

module pad_bridge_assert
(
  input logic                  I_clock,
  input logic                  I_reset,
  input logic                  select,
  input logic [`PAD_COUNT-1:0] load,
  input logic [`PAD_COUNT-1:0] rden,
  input logic [`PAD_COUNT-1:0] data
);

  logic       select_q;
  logic [7:0] stable_cycles;

  // cycles that select has held its level, the cycle of a change counts as the first
  always_ff @(posedge I_clock)
  begin
    select_q <= select;
    if (I_reset)
    begin
      stable_cycles <= '0;
    end
    else if (select != select_q)
    begin
      stable_cycles <= 8'd1;
    end
    else
    begin
      stable_cycles <= stable_cycles + 8'd1;
    end
  end

  assert property (@(posedge I_clock) disable iff (I_reset)
    (select != select_q) |-> (stable_cycles == 8'd32))
    else $error("select changed after %0d cycles instead of 32", stable_cycles);

  assert property (@(posedge I_clock) disable iff (I_reset) stable_cycles <= 8'd32)
    else $error("select held its level longer than 32 cycles");

  assert property (@(posedge I_clock) I_reset |=> !select)
    else $error("select is not low after reset");

  // a data bit may only move after a load or after the falling edge of its read strobe
  for (genvar p = 0; p < `PAD_COUNT; p++)
  begin : g_port
    assert property (@(posedge I_clock) disable iff (I_reset)
      (data[p] != $past(data[p])) |->
        ($past(load[p]) || $past(I_reset) || ($past(rden[p], 2) && !$past(rden[p]))))
      else $error("data[%0d] changed without a load or a read strobe fall", p);
  end

endmodule

bind pad_bridge_top pad_bridge_assert u_assert
(
  .I_clock (I_clock),
  .I_reset (I_reset),
  .select  (select),
  .load    (load),
  .rden    (rden),
  .data    (data)
);

//--- verif/pad_bridge_tb.sv
`timescale 1ns/1ps
`include "pad_consts.svh"

module pad_bridge_tb;

  import pad_pkg::*;

  localparam int ROWS   = 8;
  localparam int PHASE  = 1 << (`PAD_DIV_BITS - 1);
  localparam int PERIOD = 1 << `PAD_DIV_BITS;

  // one row per step
  // columns are the pressed buttons of port 0 and port 1 (a set bit is a pressed button)
  // followed by the active-low byte that each port should shift out
  localparam button_byte_t STIM_TAB [ROWS][4] = '{
    '{8'h00, 8'h00, 8'hff, 8'hff},
    '{8'h02, 8'h01, 8'hfd, 8'hfe},
    '{8'h08, 8'h04, 8'hf7, 8'hfb},
    '{8'h10, 8'h80, 8'hef, 8'h7f},
    '{8'h0a, 8'h05, 8'hf5, 8'hfa},
    '{8'h60, 8'h90, 8'h9f, 8'h6f},
    '{8'hff, 8'h5a, 8'h00, 8'ha5},
    '{8'h3c, 8'hc3, 8'hc3, 8'h3c}
  };

  logic                          I_clock;
  logic                          I_reset;
  pad_lines_t [`PAD_COUNT-1:0]   pad_lines;
  logic                          select;
  logic [`PAD_COUNT-1:0]         load;
  logic [`PAD_COUNT-1:0]         rden;
  logic [`PAD_COUNT-1:0]         data;

  // buttons currently held on each pad, a set bit is a pressed button
  button_byte_t [`PAD_COUNT-1:0] pressed;

  int checks;
  int errors;
  int timeouts;

  pad_bridge_top dut
  (
    .I_clock   (I_clock),
    .I_reset   (I_reset),
    .pad_lines (pad_lines),
    .select    (select),
    .load      (load),
    .rden      (rden),
    .data      (data)
  );

  always #20 I_clock = ~I_clock;

  // a pressed button pulls its line low only in the phase where the pad routes it
  function automatic pad_lines_t pad_model(input button_byte_t btn, input logic sel);
    pad_lines_t lines;
    lines             = '1;
    lines[LINE_UP]    = ~btn[BIT_UP];
    lines[LINE_DOWN]  = ~btn[BIT_DOWN];
    lines[LINE_LEFT]  = ~btn[BIT_LEFT];
    lines[LINE_RIGHT] = ~btn[BIT_RIGHT];
    if (sel)
    begin
      lines[LINE_BA] = ~btn[BIT_B];
      lines[LINE_CS] = ~btn[BIT_C];
    end
    else
    begin
      lines[LINE_BA] = ~btn[BIT_A];
      lines[LINE_CS] = ~btn[BIT_START];
    end
    return lines;
  endfunction

  // the pads follow select one cycle late, like a real pad behind its multiplexer
  initial
  begin
    pad_lines <= '1;
    forever
    begin
      @(posedge I_clock);
      for (int p = 0; p < `PAD_COUNT; p++)
      begin
        pad_lines[p] <= pad_model(pressed[p], select);
      end
    end
  end

  // cycles counts from the negedge after entry up to the negedge where the last change is seen
  task automatic wait_select_changes(input int changes, output int cycles, output bit ok);
    int   seen;
    int   limit;
    logic last;
    seen  = 0;
    limit = (changes + 2) * PHASE;
    @(negedge I_clock);
    last   = select;
    cycles = 1;
    while (seen < changes && cycles < limit)
    begin
      @(negedge I_clock);
      cycles++;
      if (select != last)
      begin
        seen++;
        last = select;
      end
    end
    ok = (seen == changes);
    if (!ok)
    begin
      $display("timeout: select changed %0d of %0d times within %0d cycles",
               seen, changes, cycles);
      timeouts++;
    end
  endtask

  task automatic pulse_load(input logic [`PAD_COUNT-1:0] mask);
    @(posedge I_clock);
    load <= mask;
    repeat (2) @(posedge I_clock);
    load <= '0;
  endtask

  // rden is three cycles high and three low, data is sampled in the last high cycle
  task automatic shift_and_check(input int port, input int nbits, input button_byte_t exp_byte);
    logic exp_bit;
    for (int i = 0; i < nbits; i++)
    begin
      exp_bit = (i < `PAD_BYTE_BITS) ? exp_byte[i] : 1'b0;
      @(posedge I_clock);
      rden[port] <= 1'b1;
      repeat (2) @(posedge I_clock);
      @(negedge I_clock);
      checks++;
      if (data[port] !== exp_bit)
      begin
        errors++;
        $display("CHECK FAILED data[%0d] bit %0d: got %h expected %h",
                 port, i, data[port], exp_bit);
      end
      @(posedge I_clock);
      rden[port] <= 1'b0;
      repeat (2) @(posedge I_clock);
    end
  endtask

  task automatic run_tests();
    int                    cycles;
    int                    first_len;
    bit                    ok;
    logic [`PAD_COUNT-1:0] one_port;

    @(negedge I_clock);
    checks++;
    if (select !== 1'b0)
    begin
      errors++;
      $display("CHECK FAILED select after reset: got %h expected %h", select, 1'b0);
    end

    // nothing has been committed yet so both ports hold the idle byte
    pulse_load('1);
    shift_and_check(0, `PAD_BYTE_BITS, 8'hff);
    shift_and_check(1, `PAD_BYTE_BITS, 8'hff);

    // line up on a select change first, then time two whole phases
    wait_select_changes(1, cycles, ok);
    if (!ok)
    begin
      return;
    end
    wait_select_changes(1, first_len, ok);
    if (!ok)
    begin
      return;
    end
    wait_select_changes(1, cycles, ok);
    if (!ok)
    begin
      return;
    end
    checks++;
    if (first_len != PHASE)
    begin
      errors++;
      $display("CHECK FAILED select phase length: got %h expected %h", first_len, PHASE);
    end
    checks++;
    if (first_len + cycles != PERIOD)
    begin
      errors++;
      $display("CHECK FAILED select period: got %h expected %h", first_len + cycles, PERIOD);
    end

    for (int row = 0; row < ROWS; row++)
    begin
      @(posedge I_clock);
      pressed[0] <= STIM_TAB[row][0];
      pressed[1] <= STIM_TAB[row][1];
      // three select periods give a fresh low and high sample and a commit
      wait_select_changes(6, cycles, ok);
      if (!ok)
      begin
        return;
      end
      pulse_load('1);
      shift_and_check(0, `PAD_BYTE_BITS, STIM_TAB[row][2]);
      // port 1 still shows its first bit after port 0 has been read out
      @(negedge I_clock);
      checks++;
      if (data[1] !== STIM_TAB[row][3][0])
      begin
        errors++;
        $display("CHECK FAILED data[1] after port 0 read: got %h expected %h",
                 data[1], STIM_TAB[row][3][0]);
      end
      shift_and_check(1, `PAD_BYTE_BITS, STIM_TAB[row][3]);
    end

    // a second load in the middle of a read starts over at bit 0
    // and bits past the eighth come out as zeros
    for (int port = 0; port < `PAD_COUNT; port++)
    begin
      one_port       = '0;
      one_port[port] = 1'b1;
      pulse_load(one_port);
      shift_and_check(port, 3, STIM_TAB[ROWS-1][port+2]);
      pulse_load(one_port);
      shift_and_check(port, `PAD_BYTE_BITS + 2, STIM_TAB[ROWS-1][port+2]);
    end
  endtask

  initial
  begin
    I_clock  = 1'b0;
    I_reset <= 1'b1;
    load    <= '0;
    rden    <= '0;
    pressed <= '0;
    checks   = 0;
    errors   = 0;
    timeouts = 0;
    repeat (16) @(posedge I_clock);
    I_reset <= 1'b0;
    run_tests();
    $display("checks %0d, check failures %0d, timeouts %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0)
    begin
      $display("Test OK");
    end
    else
    begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule
